/* dcache_lite.f */
+incdir+source
source/dcache_pkg.sv
source/line_move_if.sv
source/dcache_control.sv
source/main_array.sv
source/victim_buffer.sv
source/miss_table.sv
source/dcache_top.sv
testbench/tb_clock.sv
testbench/dcache_asserts.sv
testbench/dcache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb \
    -f dcache_lite.f -o dcache_sim &&
./obj_dir/dcache_sim | tee /dev/stderr | grep -x "TESTS PASSED" > /dev/null ||
{ echo "simulation did not pass"; exit 1; }

/* source/dcache_control.sv */
`timescale 1ns/10ps
`include "dcache_settings.svh"

module dcache_control (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   req_valid,
    input  logic                   req_write,
    input  dcache_pkg::req_size_t  req_size,
    input  logic [`DC_XLEN-1:0]    req_addr,
    input  logic [`DC_XLEN-1:0]    req_wdata,
    input  logic                   main_hit,
    input  logic                   victim_hit,
    input  dcache_pkg::block_t     main_hit_block,
    input  dcache_pkg::block_t     victim_hit_block,
    input  logic                   fill_valid,
    input  dcache_pkg::line_addr_t fill_addr,
    input  dcache_pkg::block_t     fill_block,
    output logic                   stall,
    output logic                   lookup,
    output logic                   miss_start,
    output dcache_pkg::line_addr_t miss_addr,
    output logic                   wait_write,
    output dcache_pkg::req_size_t  wait_size,
    output logic [`DC_XLEN-1:0]    wait_addr,
    output logic [`DC_XLEN-1:0]    wait_wdata,
    output logic                   resp_valid,
    output logic [`DC_XLEN-1:0]    resp_data
);
    typedef enum logic {READY, WAITING} state_t;

    state_t state;
    logic   hit;
    logic   fill_done;

    // pick the zero-extended byte, half or word out of a line
    function automatic logic [`DC_XLEN-1:0] extract(
        dcache_pkg::block_t         blk,
        dcache_pkg::req_size_t      size,
        logic [`DC_OFFSET_BITS-1:0] offset
    );
        logic [`DC_XLEN-1:0] data;
        data = '0;
        case (size)
            dcache_pkg::BYTE: data[7:0]  = blk[offset*8 +: 8];
            dcache_pkg::HALF: data[15:0] = blk[offset[2:1]*16 +: 16];
            default:          data       = blk[offset[2]*32 +: 32];
        endcase
        return data;
    endfunction

    assign stall      = (state == WAITING);
    assign lookup     = req_valid & (state == READY);
    assign hit        = main_hit | victim_hit;
    assign miss_start = lookup & ~hit;
    assign miss_addr  = req_addr[`DC_XLEN-1:`DC_OFFSET_BITS];

    // the miss ends on the fill of the waiting line
    assign fill_done = (state == WAITING) & fill_valid &
                       (fill_addr == wait_addr[`DC_XLEN-1:`DC_OFFSET_BITS]);

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= READY;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= (lookup & hit) | fill_done;   // one cycle after hit or fill
            if (miss_start) begin
                state <= WAITING;
            end else if (fill_done) begin
                state <= READY;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (miss_start) begin   // park the missed request
            wait_write <= req_write;
            wait_size  <= req_size;
            wait_addr  <= req_addr;
            wait_wdata <= req_wdata;
        end
        if (lookup & hit) begin
            resp_data <= extract(main_hit ? main_hit_block : victim_hit_block,
                                 req_size, req_addr[`DC_OFFSET_BITS-1:0]);
        end else if (fill_done) begin
            resp_data <= extract(fill_block, wait_size, wait_addr[`DC_OFFSET_BITS-1:0]);
        end
    end
endmodule

/* source/dcache_pkg.sv */
`include "dcache_settings.svh"

package dcache_pkg;

    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } mem_cmd_t;

    typedef enum logic [1:0] {
        BYTE = 2'h0,
        HALF = 2'h1,
        WORD = 2'h2
    } req_size_t;

    typedef logic [`DC_BLOCK_BYTES*8-1:0]        block_t;
    typedef logic [`DC_XLEN-`DC_OFFSET_BITS-1:0] line_addr_t;
    typedef logic [`DC_TAG_BITS-1:0]             mem_tag_t;

    typedef struct packed {
        logic   valid;
        logic   dirty;
        logic [`DC_XLEN-`DC_OFFSET_BITS-`DC_INDEX_BITS-1:0] tag;
        block_t block;
    } main_line_t;

    typedef struct packed {
        logic       valid;
        logic       dirty;
        line_addr_t addr;    // full line address with the index bits
        logic [$clog2(`DC_VICTIM_LINES)-1:0] lru;
        block_t     block;
    } victim_line_t;

    typedef struct packed {
        logic       valid;
        logic       is_write;
        mem_tag_t   tag;     // zero until memory accepts the command
        line_addr_t addr;
        block_t     block;   // write-back data
    } miss_entry_t;

    // drop a byte, half or word of store data into a line
    function automatic block_t merge_store(
        block_t                      blk,
        req_size_t                   size,
        logic [`DC_OFFSET_BITS-1:0]  offset,
        logic [`DC_XLEN-1:0]         wdata
    );
        block_t merged;
        merged = blk;
        case (size)
            BYTE:    merged[offset*8 +: 8]       = wdata[7:0];
            HALF:    merged[offset[2:1]*16 +: 16] = wdata[15:0];
            default: merged[offset[2]*32 +: 32]   = wdata[31:0];
        endcase
        return merged;
    endfunction

endpackage

/* source/dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

`define DC_XLEN          32
`define DC_BLOCK_BYTES   8      // bytes per cache line
`define DC_OFFSET_BITS   3
`define DC_MAIN_LINES    8
`define DC_INDEX_BITS    3
`define DC_VICTIM_LINES  4
`define DC_MISS_ENTRIES  4
`define DC_TAG_BITS      4      // memory transaction tag where zero means none

`endif

/* source/dcache_top.sv */
`timescale 1ns/10ps
`include "dcache_settings.svh"

module dcache_top (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  req_valid,
    input  logic                  req_write,
    input  dcache_pkg::req_size_t req_size,
    input  logic [`DC_XLEN-1:0]   req_addr,
    input  logic [`DC_XLEN-1:0]   req_wdata,
    output logic                  stall,
    output logic                  resp_valid,
    output logic [`DC_XLEN-1:0]   resp_data,
    output dcache_pkg::mem_cmd_t  mem_command,
    output logic [`DC_XLEN-1:0]   mem_addr,
    output dcache_pkg::block_t    mem_wdata,
    input  dcache_pkg::mem_tag_t  mem_accept_tag,
    input  dcache_pkg::mem_tag_t  mem_resp_tag,
    input  dcache_pkg::block_t    mem_resp_data
);
    logic                   lookup;
    logic                   main_hit;
    logic                   victim_hit;
    dcache_pkg::block_t     main_hit_block;
    dcache_pkg::block_t     victim_hit_block;
    logic                   miss_start;
    dcache_pkg::line_addr_t miss_addr;
    logic                   fill_valid;
    dcache_pkg::line_addr_t fill_addr;
    dcache_pkg::block_t     fill_block;
    logic                   wait_write;
    dcache_pkg::req_size_t  wait_size;
    logic [`DC_XLEN-1:0]    wait_addr;
    logic [`DC_XLEN-1:0]    wait_wdata;

    line_move_if evict_main ();     // main array to victim buffer
    line_move_if evict_victim ();   // dirty victims to the miss table

    dcache_control dcache_control_inst (.*);

    main_array main_array_inst (
        .*,
        .evict (evict_main)
    );

    victim_buffer victim_buffer_inst (
        .*,
        .incoming (evict_main),
        .evict    (evict_victim)
    );

    miss_table miss_table_inst (
        .*,
        .writeback (evict_victim)
    );
endmodule

/* source/line_move_if.sv */
`timescale 1ns/10ps

// one cache line handed from one array to the next for a single cycle
interface line_move_if;
    logic                   valid;
    logic                   dirty;
    dcache_pkg::line_addr_t addr;    // offset bits dropped
    dcache_pkg::block_t     block;

    modport source (output valid, output dirty, output addr, output block);
    modport sink   (input valid, input dirty, input addr, input block);
endinterface

/* source/main_array.sv */
`timescale 1ns/10ps
`include "dcache_settings.svh"

module main_array (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   lookup,
    input  logic                   req_write,
    input  dcache_pkg::req_size_t  req_size,
    input  logic [`DC_XLEN-1:0]    req_addr,
    input  logic [`DC_XLEN-1:0]    req_wdata,
    input  logic                   fill_valid,
    input  dcache_pkg::line_addr_t fill_addr,
    input  dcache_pkg::block_t     fill_block,
    input  logic                   wait_write,
    input  dcache_pkg::req_size_t  wait_size,
    input  logic [`DC_XLEN-1:0]    wait_addr,
    input  logic [`DC_XLEN-1:0]    wait_wdata,
    output logic                   main_hit,
    output dcache_pkg::block_t     main_hit_block,
    line_move_if.source            evict
);
    localparam int TAG_LSB = `DC_OFFSET_BITS + `DC_INDEX_BITS;

    dcache_pkg::main_line_t    lines [`DC_MAIN_LINES];
    dcache_pkg::main_line_t    old_line;    // line sitting where the fill goes
    logic [`DC_INDEX_BITS-1:0] req_index;
    logic [`DC_INDEX_BITS-1:0] fill_index;
    dcache_pkg::block_t        fill_data;

    assign req_index  = req_addr[TAG_LSB-1:`DC_OFFSET_BITS];
    assign fill_index = fill_addr[`DC_INDEX_BITS-1:0];
    assign old_line   = lines[fill_index];

    assign main_hit = lookup & lines[req_index].valid &
                      (lines[req_index].tag == req_addr[`DC_XLEN-1:TAG_LSB]);
    assign main_hit_block = lines[req_index].block;

    // a store miss lands in the refilled line right away
    assign fill_data = wait_write ?
        dcache_pkg::merge_store(fill_block, wait_size, wait_addr[`DC_OFFSET_BITS-1:0],
                                wait_wdata) :
        fill_block;

    assign evict.valid = fill_valid & old_line.valid;
    assign evict.dirty = old_line.dirty;
    assign evict.addr  = {old_line.tag, fill_index};
    assign evict.block = old_line.block;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `DC_MAIN_LINES; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else if (fill_valid) begin
            lines[fill_index] <= '{valid: 1'b1,
                                   dirty: wait_write,
                                   tag:   fill_addr[`DC_XLEN-`DC_OFFSET_BITS-1:`DC_INDEX_BITS],
                                   block: fill_data};
        end else if (main_hit & req_write) begin
            lines[req_index].dirty <= 1'b1;
            lines[req_index].block <= dcache_pkg::merge_store(lines[req_index].block, req_size,
                                          req_addr[`DC_OFFSET_BITS-1:0], req_wdata);
        end
    end
endmodule

/* source/miss_table.sv */
`timescale 1ns/10ps
`include "dcache_settings.svh"

module miss_table (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   miss_start,
    input  dcache_pkg::line_addr_t miss_addr,
    input  dcache_pkg::mem_tag_t   mem_accept_tag,
    input  dcache_pkg::mem_tag_t   mem_resp_tag,
    input  dcache_pkg::block_t     mem_resp_data,
    line_move_if.sink              writeback,
    output dcache_pkg::mem_cmd_t   mem_command,
    output logic [`DC_XLEN-1:0]    mem_addr,
    output dcache_pkg::block_t     mem_wdata,
    output logic                   fill_valid,
    output dcache_pkg::line_addr_t fill_addr,
    output dcache_pkg::block_t     fill_block
);
    localparam int ENTRY_BITS = $clog2(`DC_MISS_ENTRIES);

    dcache_pkg::miss_entry_t entries [`DC_MISS_ENTRIES];
    logic [ENTRY_BITS-1:0]   free_index;
    logic [ENTRY_BITS-1:0]   wr_index;
    logic [ENTRY_BITS-1:0]   rd_index;
    logic [ENTRY_BITS-1:0]   issue_index;
    logic [ENTRY_BITS-1:0]   resp_index;
    logic                    wr_found;
    logic                    rd_found;
    logic                    issue;
    logic                    accepted;

    // scan for a free slot, the lowest unissued write and the unissued read
    always_comb begin
        free_index = '0;
        wr_found   = 1'b0;
        wr_index   = '0;
        rd_found   = 1'b0;
        rd_index   = '0;
        for (int i = `DC_MISS_ENTRIES-1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                free_index = ENTRY_BITS'(i);
            end else if (entries[i].tag == '0) begin
                if (entries[i].is_write) begin
                    wr_found = 1'b1;
                    wr_index = ENTRY_BITS'(i);
                end else begin
                    rd_found = 1'b1;
                    rd_index = ENTRY_BITS'(i);
                end
            end
        end
    end

    assign issue       = wr_found | rd_found;
    assign issue_index = wr_found ? wr_index : rd_index;   // write-backs go first
    assign accepted    = issue & (mem_accept_tag != '0);

    assign mem_command = !issue ? dcache_pkg::BUS_NONE :
                         entries[issue_index].is_write ? dcache_pkg::BUS_STORE :
                                                         dcache_pkg::BUS_LOAD;
    assign mem_addr  = {entries[issue_index].addr, {`DC_OFFSET_BITS{1'b0}}};
    assign mem_wdata = entries[issue_index].block;

    // match the returning tag against issued reads
    always_comb begin
        fill_valid = 1'b0;
        resp_index = '0;
        for (int i = 0; i < `DC_MISS_ENTRIES; i++) begin
            if (entries[i].valid & !entries[i].is_write & (entries[i].tag != '0) &
                (entries[i].tag == mem_resp_tag)) begin
                fill_valid = 1'b1;
                resp_index = ENTRY_BITS'(i);
            end
        end
    end

    assign fill_addr  = entries[resp_index].addr;
    assign fill_block = mem_resp_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `DC_MISS_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            if (accepted) begin
                if (entries[issue_index].is_write) begin
                    entries[issue_index].valid <= 1'b0;   // nothing comes back for a store
                end else begin
                    entries[issue_index].tag <= mem_accept_tag;
                end
            end
            if (fill_valid) begin
                entries[resp_index].valid <= 1'b0;
            end
            if (miss_start) begin
                entries[free_index] <= '{valid: 1'b1, is_write: 1'b0, tag: '0,
                                         addr: miss_addr, block: '0};
            end else if (writeback.valid) begin
                entries[free_index] <= '{valid: 1'b1, is_write: 1'b1, tag: '0,
                                         addr: writeback.addr, block: writeback.block};
            end
        end
    end
endmodule

/* source/victim_buffer.sv */
`timescale 1ns/10ps
`include "dcache_settings.svh"

module victim_buffer (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  lookup,
    input  logic                  req_write,
    input  dcache_pkg::req_size_t req_size,
    input  logic [`DC_XLEN-1:0]   req_addr,
    input  logic [`DC_XLEN-1:0]   req_wdata,
    output logic                  victim_hit,
    output dcache_pkg::block_t    victim_hit_block,
    line_move_if.sink             incoming,
    line_move_if.source           evict
);
    localparam int SLOT_BITS = $clog2(`DC_VICTIM_LINES);

    dcache_pkg::victim_line_t lines [`DC_VICTIM_LINES];
    dcache_pkg::line_addr_t   req_line;
    logic [SLOT_BITS-1:0]     hit_slot;
    logic [SLOT_BITS-1:0]     free_slot;
    logic [SLOT_BITS-1:0]     lru_slot;
    logic [SLOT_BITS-1:0]     fill_slot;
    logic                     full;

    assign req_line = req_addr[`DC_XLEN-1:`DC_OFFSET_BITS];

    always_comb begin
        victim_hit = 1'b0;
        hit_slot   = '0;
        for (int i = `DC_VICTIM_LINES-1; i >= 0; i--) begin
            if (lookup & lines[i].valid & (lines[i].addr == req_line)) begin
                victim_hit = 1'b1;
                hit_slot   = SLOT_BITS'(i);
            end
        end
    end

    assign victim_hit_block = lines[hit_slot].block;

    // first free slot, and the lowest lru value for when all are taken
    always_comb begin
        full      = 1'b1;
        free_slot = '0;
        lru_slot  = '0;
        for (int i = `DC_VICTIM_LINES-1; i >= 0; i--) begin
            if (!lines[i].valid) begin
                full      = 1'b0;
                free_slot = SLOT_BITS'(i);
            end
            if (lines[i].lru <= lines[lru_slot].lru) begin
                lru_slot = SLOT_BITS'(i);   // ties go to the lower slot
            end
        end
    end

    assign fill_slot = full ? lru_slot : free_slot;

    // clean lines simply fall out, dirty ones head for memory
    assign evict.valid = incoming.valid & full & lines[lru_slot].dirty;
    assign evict.dirty = lines[lru_slot].dirty;
    assign evict.addr  = lines[lru_slot].addr;
    assign evict.block = lines[lru_slot].block;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `DC_VICTIM_LINES; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else if (incoming.valid) begin
            lines[fill_slot] <= '{valid: 1'b1, dirty: incoming.dirty, addr: incoming.addr,
                                  lru: '0, block: incoming.block};
        end else if (victim_hit) begin
            for (int i = 0; i < `DC_VICTIM_LINES; i++) begin
                if (SLOT_BITS'(i) == hit_slot) begin
                    lines[i].lru <= '1;
                end else if (lines[i].lru != '0) begin
                    lines[i].lru <= lines[i].lru - 1'b1;
                end
            end
            if (req_write) begin
                lines[hit_slot].dirty <= 1'b1;
                lines[hit_slot].block <= dcache_pkg::merge_store(lines[hit_slot].block,
                                             req_size, req_addr[`DC_OFFSET_BITS-1:0], req_wdata);
            end
        end
    end
endmodule

/* testbench/dcache_asserts.sv */
`timescale 1ns/10ps

module dcache_asserts (
    input logic                 clock,
    input logic                 reset,
    input logic                 stall,
    input logic                 resp_valid,
    input dcache_pkg::mem_cmd_t mem_command,
    input dcache_pkg::mem_tag_t mem_accept_tag
);
    // a response means the cache is ready again
    resp_not_stalled: assert property (@(posedge clock) disable iff (reset)
        !(resp_valid && stall))
        else $error("resp_valid seen while stall is high");

    bus_idle_in_reset: assert property (@(posedge clock)
        reset && $past(reset) |-> mem_command == dcache_pkg::BUS_NONE)
        else $error("memory command issued during reset");

    accept_needs_command: assert property (@(posedge clock) disable iff (reset)
        mem_accept_tag != '0 |-> mem_command != dcache_pkg::BUS_NONE)
        else $error("accept tag given with no command on the bus");
endmodule

bind dcache_top dcache_asserts dcache_asserts_inst (
    .clock          (clock),
    .reset          (reset),
    .stall          (stall),
    .resp_valid     (resp_valid),
    .mem_command    (mem_command),
    .mem_accept_tag (mem_accept_tag)
);

/* testbench/dcache_stimulus.txt */
// write size(0 byte, 1 half, 2 word) address store_data expected_load hit
// unwritten memory holds the block address in both words
0 2 12345680 00000000 12345680 0
0 0 12345683 00000000 00000012 1
0 1 12345686 00000000 00001234 1
0 0 12345689 00000000 00000056 0
0 1 12345692 00000000 00001234 0
1 0 12345681 000000aa 00000000 1
1 1 12345686 0000beef 00000000 1
0 2 12345680 00000000 1234aa80 1
0 2 12345684 00000000 beef5680 1
1 2 12345698 cafef00d 00000000 0
0 2 12345698 00000000 cafef00d 1
1 0 123456a7 00000055 00000000 0
0 2 123456a4 00000000 553456a0 1
0 2 123456c0 00000000 123456c0 0
0 2 12345680 00000000 1234aa80 1
1 2 12345700 11111111 00000000 0
1 2 12345740 22222222 00000000 0
1 2 12345780 33333333 00000000 0
1 2 123457c0 44444444 00000000 0
1 2 12345800 55555555 00000000 0
1 2 12345840 66666666 00000000 0
0 2 12345780 00000000 33333333 0
0 2 123457c0 00000000 44444444 0
0 2 12345800 00000000 55555555 0
0 2 12345840 00000000 66666666 0
0 2 12345700 00000000 11111111 1
0 1 12345742 00000000 00002222 1

/* testbench/dcache_tb.sv */
`timescale 1ns/10ps
`include "dcache_settings.svh"

module dcache_tb;
    localparam int MAX_REQS  = 40;
    localparam int FIELDS    = 6;     // columns per request in the stimulus file
    localparam int TIMEOUT   = 200;
    localparam int MEM_DELAY = 3;

    logic                   clock;
    logic                   reset;
    logic                   req_valid;
    logic                   req_write;
    dcache_pkg::req_size_t  req_size;
    logic [`DC_XLEN-1:0]    req_addr;
    logic [`DC_XLEN-1:0]    req_wdata;
    logic                   stall;
    logic                   resp_valid;
    logic [`DC_XLEN-1:0]    resp_data;
    dcache_pkg::mem_cmd_t   mem_command;
    logic [`DC_XLEN-1:0]    mem_addr;
    dcache_pkg::block_t     mem_wdata;
    dcache_pkg::mem_tag_t   mem_accept_tag;
    dcache_pkg::mem_tag_t   mem_resp_tag;
    dcache_pkg::block_t     mem_resp_data;

    logic [31:0]            stim [0:MAX_REQS*FIELDS-1];
    dcache_pkg::block_t     memory [dcache_pkg::line_addr_t];   // only lines written so far
    dcache_pkg::mem_tag_t   pend_tag [$];
    dcache_pkg::block_t     pend_data [$];
    int                     pend_due [$];
    dcache_pkg::mem_tag_t   next_tag;
    int                     cycle;
    int                     loads_seen;
    int                     stores_seen;
    int                     errors;
    bit                     timed_out;

    tb_clock clock_gen (.clock(clock));

    dcache_top dcache_top_inst (.*);

    // untouched memory holds the block's own address in both words
    function automatic dcache_pkg::block_t read_block(dcache_pkg::line_addr_t line);
        logic [31:0] base;
        base = {line, {`DC_OFFSET_BITS{1'b0}}};
        if (memory.exists(line)) begin
            return memory[line];
        end
        return {base, base};
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected %h got %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_idle();
        check_value("stall", 0, stall);
        check_value("resp_valid", 0, resp_valid);
        check_value("mem_command", dcache_pkg::BUS_NONE, mem_command);
    endtask

    task automatic wait_stall_low();
        int waited;
        waited = 0;
        while (stall && waited < TIMEOUT) begin
            @(negedge clock);
            waited++;
        end
        if (stall) begin
            $display("timeout: stall stayed high for %0d cycles", TIMEOUT);
            timed_out = 1'b1;
            errors++;
        end
    endtask

    task automatic wait_response(output int waited);
        waited = 1;   // the request cycle itself
        while (!resp_valid && waited < TIMEOUT) begin
            @(negedge clock);
            waited++;
        end
        if (!resp_valid) begin
            $display("timeout: no response to the request at address %h", req_addr);
            timed_out = 1'b1;
            errors++;
        end
    endtask

    task automatic run_request(input int idx);
        logic        expect_hit;
        int          loads_before;
        int          waited;
        expect_hit = stim[idx*FIELDS+5][0];
        wait_stall_low();
        if (timed_out) begin
            return;
        end
        req_valid    = 1'b1;
        req_write    = stim[idx*FIELDS][0];
        req_size     = dcache_pkg::req_size_t'(stim[idx*FIELDS+1][1:0]);
        req_addr     = stim[idx*FIELDS+2];
        req_wdata    = stim[idx*FIELDS+3];
        loads_before = loads_seen;
        @(negedge clock);
        req_valid = 1'b0;
        check_value("stall", !expect_hit, stall);   // a miss stalls in the next cycle
        wait_response(waited);
        if (timed_out) begin
            return;
        end
        if (expect_hit) begin
            check_value("hit_latency", 1, waited);
        end
        check_value("load_commands", expect_hit ? 0 : 1, loads_seen - loads_before);
        if (!req_write) begin
            check_value("resp_data", stim[idx*FIELDS+4], resp_data);
        end
    endtask

    // memory model that accepts every command at once
    always @(negedge clock) begin
        cycle++;
        mem_accept_tag = '0;
        mem_resp_tag   = '0;
        if (!reset && mem_command != dcache_pkg::BUS_NONE) begin
            mem_accept_tag = next_tag;
            if (mem_command == dcache_pkg::BUS_STORE) begin
                memory[mem_addr[`DC_XLEN-1:`DC_OFFSET_BITS]] = mem_wdata;
                stores_seen++;
            end else begin
                pend_tag.push_back(next_tag);
                pend_data.push_back(read_block(mem_addr[`DC_XLEN-1:`DC_OFFSET_BITS]));
                pend_due.push_back(cycle + MEM_DELAY);
                loads_seen++;
            end
            next_tag = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;   // zero is never a tag
        end
        if (pend_due.size() > 0 && pend_due[0] == cycle) begin
            mem_resp_tag  = pend_tag.pop_front();
            mem_resp_data = pend_data.pop_front();
            pend_due.delete(0);
        end
    end

    initial begin
        int req_count;
        reset          = 1'b1;
        req_valid      = 1'b0;
        req_write      = 1'b0;
        req_size       = dcache_pkg::WORD;
        req_addr       = '0;
        req_wdata      = '0;
        mem_accept_tag = '0;
        mem_resp_tag   = '0;
        mem_resp_data  = '0;
        next_tag       = 4'h1;
        cycle          = 0;
        loads_seen     = 0;
        stores_seen    = 0;
        errors         = 0;
        timed_out      = 1'b0;
        for (int i = 0; i < MAX_REQS*FIELDS; i++) begin
            stim[i] = '1;   // end marker where the file stops
        end
        $readmemh("testbench/dcache_stimulus.txt", stim);

        repeat (8) begin
            @(negedge clock);
            check_idle();
        end
        reset = 1'b0;
        @(negedge clock);
        check_idle();

        req_count = 0;
        while (!timed_out && req_count < MAX_REQS && stim[req_count*FIELDS] != '1) begin
            run_request(req_count);
            req_count++;
        end
        check_value("store_commands", 4, stores_seen);   // dirty victims pushed to memory

        $display("requests run: %0d, errors: %0d", req_count, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end
endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD = 20   // ns
) (
    output logic clock = 1'b0
);
    always #(PERIOD / 2) clock = ~clock;
endmodule
